// ==== source/core_bus_pkg.sv ====
package core_bus_pkg;

    // data and address width of the core
    localparam int XLEN = 64;

    typedef logic [XLEN-1:0] addr_t;    // byte address
    typedef logic [XLEN-1:0] data_t;    // one data word

    // requesters sharing the bus
    localparam int NUM_PORTS = 2;

    typedef logic [$clog2(NUM_PORTS)-1:0] port_t;

    localparam port_t PORT_FETCH = 1'b0;    // instruction fetch
    localparam port_t PORT_LOAD  = 1'b1;    // load unit, wins ties

    // everything from here upward is device space
    localparam addr_t MMIO_BASE = 64'h0000_0000_A000_0000;

    // plain read request from the core side
    // valid is a level, held with stable addr/size until done
    typedef struct packed {
        logic       valid;
        addr_t      addr;
        logic [2:0] size;    // axi size code
    } core_req_t;

    // read response back to the core side
    typedef struct packed {
        logic  done;    // one-cycle pulse
        data_t data;
        logic  err;     // slave answered with something other than okay
    } core_rsp_t;

endpackage

// ==== source/axi_lite_pkg.sv ====
package axi_lite_pkg;

    // transfer size, bytes = 2**size
    typedef logic [2:0] size_t;

    localparam size_t SIZE_WORD = 3'd2;    // 32-bit instruction word

    // read response code
    typedef logic [1:0] resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    // arprot, bit 2 marks an instruction access
    localparam logic [2:0] PROT_DATA  = 3'b000;
    localparam logic [2:0] PROT_INSTR = 3'b100;

    // read address channel, single beat only
    // ready runs the other way as its own bit
    typedef struct packed {
        logic                valid;
        core_bus_pkg::addr_t addr;
        size_t               size;
        logic [2:0]          prot;
    } ar_chan_t;

    // read data channel
    typedef struct packed {
        logic                valid;
        core_bus_pkg::data_t data;
        resp_t               resp;
    } r_chan_t;

endpackage

// ==== source/axi_read_master.sv ====
`timescale 1ns/1ns

module axi_read_master (
    input  logic                    clk,
    input  logic                    reset_i,
    input  core_bus_pkg::core_req_t req_i,
    output core_bus_pkg::core_rsp_t rsp_o,
    output axi_lite_pkg::ar_chan_t  ar_o,
    input  logic                    ar_ready_i,
    input  axi_lite_pkg::r_chan_t   r_i,
    output logic                    r_ready_o,
    input  logic                    instr_i     // strap, fetch side of the core
);
    import core_bus_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ADDR,
        ST_DATA
    } state_e;

    state_e state_q;
    addr_t  addr_q;     // latched request address
    size_t  size_q;
    data_t  data_q;
    logic   err_q;
    logic   done_q;
    logic   start;
    logic   ar_fire;
    logic   r_fire;

    // the core still holds valid while done is high, so skip that cycle
    assign start   = (state_q == ST_IDLE) && req_i.valid && !done_q;
    assign ar_fire = (state_q == ST_ADDR) && ar_ready_i;
    assign r_fire  = (state_q == ST_DATA) && r_i.valid;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= ST_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= r_fire;    // pulse one cycle after the r beat
            case (state_q)
                ST_IDLE: begin
                    if (start) begin
                        state_q <= ST_ADDR;
                    end
                end
                ST_ADDR: begin
                    if (ar_fire) begin
                        state_q <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (r_fire) begin
                        state_q <= ST_IDLE;
                    end
                end
                default: begin
                    state_q <= ST_IDLE;
                end
            endcase
        end
    end

    // request payload, captured once per read
    always_ff @(posedge clk) begin
        if (start) begin
            addr_q <= req_i.addr;
            size_q <= instr_i ? SIZE_WORD : req_i.size;    // fetch is always a word
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (r_fire) begin
            data_q <= r_i.data;
            err_q  <= (r_i.resp != RESP_OKAY);
        end
    end

    always_comb begin
        ar_o.valid = (state_q == ST_ADDR);    // held until accepted
        ar_o.addr  = addr_q;
        ar_o.size  = size_q;
        ar_o.prot  = instr_i ? PROT_INSTR : PROT_DATA;
    end

    assign r_ready_o = (state_q == ST_DATA);

    always_comb begin
        rsp_o.done = done_q;
        rsp_o.data = data_q;
        rsp_o.err  = err_q;
    end

endmodule

// ==== source/axi_read_crossbar.sv ====
`timescale 1ns/1ns

module axi_read_crossbar (
    input  logic                                                 clk,
    input  logic                                                 reset_i,
    // requester side
    input  axi_lite_pkg::ar_chan_t [core_bus_pkg::NUM_PORTS-1:0] m_ar_i,
    output logic [core_bus_pkg::NUM_PORTS-1:0]                   m_ar_ready_o,
    output axi_lite_pkg::r_chan_t  [core_bus_pkg::NUM_PORTS-1:0] m_r_o,
    input  logic [core_bus_pkg::NUM_PORTS-1:0]                   m_r_ready_i,
    // memory slave
    output axi_lite_pkg::ar_chan_t                               mem_ar_o,
    input  logic                                                 mem_ar_ready_i,
    input  axi_lite_pkg::r_chan_t                                mem_r_i,
    output logic                                                 mem_r_ready_o,
    // mmio slave
    output axi_lite_pkg::ar_chan_t                               mmio_ar_o,
    input  logic                                                 mmio_ar_ready_i,
    input  axi_lite_pkg::r_chan_t                                mmio_r_i,
    output logic                                                 mmio_r_ready_o
);
    import core_bus_pkg::*;
    import axi_lite_pkg::*;

    typedef enum logic {
        XB_IDLE,
        XB_BUSY
    } xb_state_e;

    xb_state_e state_q;
    port_t     gnt_q;           // requester owning the crossbar
    logic      mmio_q;          // target slave of the granted read
    port_t     req_sel;
    logic      req_any;
    logic      req_mmio;
    ar_chan_t  gnt_ar;
    r_chan_t   slv_r;
    logic      slv_ar_ready;
    logic      busy;
    logic      r_fire;

    // fixed priority, load before fetch
    assign req_any  = m_ar_i[PORT_LOAD].valid || m_ar_i[PORT_FETCH].valid;
    assign req_sel  = m_ar_i[PORT_LOAD].valid ? PORT_LOAD : PORT_FETCH;
    assign req_mmio = (m_ar_i[req_sel].addr >= MMIO_BASE);    // address decode

    assign busy         = (state_q == XB_BUSY);
    assign gnt_ar       = m_ar_i[gnt_q];
    assign slv_r        = mmio_q ? mmio_r_i : mem_r_i;
    assign slv_ar_ready = mmio_q ? mmio_ar_ready_i : mem_ar_ready_i;

    // grant ends with the single r beat
    assign r_fire = busy && slv_r.valid && m_r_ready_i[gnt_q];

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= XB_IDLE;
            gnt_q   <= PORT_FETCH;
            mmio_q  <= 1'b0;
        end else begin
            case (state_q)
                XB_IDLE: begin
                    if (req_any) begin
                        state_q <= XB_BUSY;
                        gnt_q   <= req_sel;
                        mmio_q  <= req_mmio;
                    end
                end
                XB_BUSY: begin
                    if (r_fire) begin
                        state_q <= XB_IDLE;
                    end
                end
                default: begin
                    state_q <= XB_IDLE;
                end
            endcase
        end
    end

    // address path, only the granted requester reaches a slave
    always_comb begin
        mem_ar_o     = '0;
        mmio_ar_o    = '0;
        m_ar_ready_o = '0;    // loser waits here
        if (busy) begin
            if (mmio_q) begin
                mmio_ar_o = gnt_ar;
            end else begin
                mem_ar_o = gnt_ar;
            end
            m_ar_ready_o[gnt_q] = slv_ar_ready;
        end
    end

    // data path back from the same slave
    always_comb begin
        m_r_o          = '0;
        mem_r_ready_o  = 1'b0;
        mmio_r_ready_o = 1'b0;
        if (busy) begin
            m_r_o[gnt_q] = slv_r;
            if (mmio_q) begin
                mmio_r_ready_o = m_r_ready_i[gnt_q];
            end else begin
                mem_r_ready_o = m_r_ready_i[gnt_q];
            end
        end
    end

endmodule

// ==== source/core_bus_top.sv ====
`timescale 1ns/1ns

module core_bus_top (
    input  logic                                                  clk,
    input  logic                                                  reset_i,
    // core side, indexed by port
    input  core_bus_pkg::core_req_t [core_bus_pkg::NUM_PORTS-1:0] req_i,
    output core_bus_pkg::core_rsp_t [core_bus_pkg::NUM_PORTS-1:0] rsp_o,
    // memory port
    output axi_lite_pkg::ar_chan_t                                mem_ar_o,
    input  logic                                                  mem_ar_ready_i,
    input  axi_lite_pkg::r_chan_t                                 mem_r_i,
    output logic                                                  mem_r_ready_o,
    // mmio port
    output axi_lite_pkg::ar_chan_t                                mmio_ar_o,
    input  logic                                                  mmio_ar_ready_i,
    input  axi_lite_pkg::r_chan_t                                 mmio_r_i,
    output logic                                                  mmio_r_ready_o
);
    import core_bus_pkg::*;
    import axi_lite_pkg::*;

    ar_chan_t [NUM_PORTS-1:0] m_ar;          // requester ar into crossbar
    logic     [NUM_PORTS-1:0] m_ar_ready;
    r_chan_t  [NUM_PORTS-1:0] m_r;           // r back to requesters
    logic     [NUM_PORTS-1:0] m_r_ready;

    genvar g;
    for (g = 0; g < NUM_PORTS; g++) begin : g_req
        axi_read_master u_master (
            .clk        (clk),
            .reset_i    (reset_i),
            .req_i      (req_i[g]),
            .rsp_o      (rsp_o[g]),
            .ar_o       (m_ar[g]),
            .ar_ready_i (m_ar_ready[g]),
            .r_i        (m_r[g]),
            .r_ready_o  (m_r_ready[g]),
            .instr_i    (g == PORT_FETCH)    // prot strap per slot
        );
    end

    axi_read_crossbar u_xbar (
        .clk             (clk),
        .reset_i         (reset_i),
        .m_ar_i          (m_ar),
        .m_ar_ready_o    (m_ar_ready),
        .m_r_o           (m_r),
        .m_r_ready_i     (m_r_ready),
        .mem_ar_o        (mem_ar_o),
        .mem_ar_ready_i  (mem_ar_ready_i),
        .mem_r_i         (mem_r_i),
        .mem_r_ready_o   (mem_r_ready_o),
        .mmio_ar_o       (mmio_ar_o),
        .mmio_ar_ready_i (mmio_ar_ready_i),
        .mmio_r_i        (mmio_r_i),
        .mmio_r_ready_o  (mmio_r_ready_o)
    );

endmodule

// ==== test/tb_core_bus_top.sv ====
`timescale 1ns/1ns

module tb_core_bus_top;
    import core_bus_pkg::*;
    import axi_lite_pkg::*;

    localparam data_t MEM_PATTERN    = 64'h5A5A_0F0F_C3C3_1234;
    localparam data_t MMIO_PATTERN   = 64'hD00D_F00D_0BAD_CAFE;
    localparam int    TOTAL_REQS     = 44;    // 1 + 1 + 2 + 40
    localparam int    CYCLES_PER_REQ = 40;
    localparam int    TIMEOUT_CYCLES = CYCLES_PER_REQ * TOTAL_REQS;

    logic                           clk;
    logic                           reset_i;
    core_req_t [NUM_PORTS-1:0]      req;
    core_rsp_t [NUM_PORTS-1:0]      rsp;
    ar_chan_t                       mem_ar;
    logic                           mem_ar_ready;
    r_chan_t                        mem_r;
    logic                           mem_r_ready;
    ar_chan_t                       mmio_ar;
    logic                           mmio_ar_ready;
    r_chan_t                        mmio_r;
    logic                           mmio_r_ready;

    int     seed = 78647;
    int     cycle = 0;
    int     errors = 0;
    int     tests_run = 0;
    int     tests_failed = 0;
    string  cur_test = "reset";
    data_t  exp_data [NUM_PORTS];     // expected data of the read in flight
    int     issued [NUM_PORTS];
    int     done_cnt [NUM_PORTS];
    int     done_cycle [NUM_PORTS];
    int     mem_ar_count = 0;
    int     mmio_ar_count = 0;
    size_t  mem_last_size;
    size_t  mmio_last_size;
    logic [2:0] mem_last_prot;
    logic [2:0] mmio_last_prot;

    core_bus_top u_dut (
        .clk             (clk),
        .reset_i         (reset_i),
        .req_i           (req),
        .rsp_o           (rsp),
        .mem_ar_o        (mem_ar),
        .mem_ar_ready_i  (mem_ar_ready),
        .mem_r_i         (mem_r),
        .mem_r_ready_o   (mem_r_ready),
        .mmio_ar_o       (mmio_ar),
        .mmio_ar_ready_i (mmio_ar_ready),
        .mmio_r_i        (mmio_r),
        .mmio_r_ready_o  (mmio_r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reference model of the two slaves
    function automatic data_t expected_data(input addr_t addr);
        if (addr >= MMIO_BASE) return addr ^ MMIO_PATTERN;
        return addr ^ MEM_PATTERN;
    endfunction

    function automatic int slave_delay();
        return $unsigned($random(seed)) % 4;
    endfunction

    function automatic addr_t random_addr();
        logic [31:0] r;
        r = $random(seed);
        if (r[31]) return MMIO_BASE + {32'h0, r & 32'h0FFF_FFF8};    // device side
        return {32'h0, r & 32'h7FFF_FFF8};
    endfunction

    // one core read held until done
    task automatic do_read(input port_t port, input addr_t addr, input size_t size);
        exp_data[port] = expected_data(addr);
        issued[port]++;
        @(posedge clk);
        req[port] <= {1'b1, addr, size};
        do @(negedge clk); while (!rsp[port].done);
        @(posedge clk);
        req[port].valid <= 1'b0;
    endtask

    task automatic random_reads(input port_t port, input int count);
        addr_t addr;
        size_t size;
        int    gap;
        for (int i = 0; i < count; i++) begin
            addr = random_addr();
            size = (port == PORT_FETCH) ? SIZE_WORD : size_t'($unsigned($random(seed)) % 4);
            do_read(port, addr, size);
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) @(posedge clk);
        end
    endtask

    task automatic check_value(input string what, input longint exp, input longint act);
        assert (exp == act) else begin
            $display("mismatch %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
            errors++;
        end
    endtask

    task automatic report_test(input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            $display("test %s: ok", cur_test);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", cur_test, errors - errs_before);
        end
    endtask

    initial begin : mem_slave
        addr_t addr;
        int    delay;
        mem_ar_ready = 1'b0;
        mem_r        = '0;
        forever begin
            @(negedge clk);
            if (mem_ar.valid) begin
                addr          = mem_ar.addr;
                mem_last_size = mem_ar.size;
                mem_last_prot = mem_ar.prot;
                mem_ar_count++;
                delay = slave_delay();
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_ar_ready <= 1'b1;
                @(posedge clk);                // ar handshake edge
                mem_ar_ready <= 1'b0;
                delay = slave_delay();
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mem_r <= {1'b1, addr ^ MEM_PATTERN, RESP_OKAY};
                do @(negedge clk); while (!mem_r_ready);
                @(posedge clk);
                mem_r <= '0;
            end
        end
    end

    initial begin : mmio_slave
        addr_t addr;
        int    delay;
        mmio_ar_ready = 1'b0;
        mmio_r        = '0;
        forever begin
            @(negedge clk);
            if (mmio_ar.valid) begin
                addr           = mmio_ar.addr;
                mmio_last_size = mmio_ar.size;
                mmio_last_prot = mmio_ar.prot;
                mmio_ar_count++;
                delay = slave_delay();
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mmio_ar_ready <= 1'b1;
                @(posedge clk);
                mmio_ar_ready <= 1'b0;
                delay = slave_delay();
                repeat (delay) @(posedge clk);
                @(posedge clk);
                mmio_r <= {1'b1, addr ^ MMIO_PATTERN, RESP_OKAY};
                do @(negedge clk); while (!mmio_r_ready);
                @(posedge clk);
                mmio_r <= '0;
            end
        end
    end

    // compares every done pulse with the reference
    initial begin : rsp_checker
        done_cnt   = '{default: 0};
        done_cycle = '{default: 0};
        forever begin
            @(negedge clk);
            for (int p = 0; p < NUM_PORTS; p++) begin
                if (!reset_i && rsp[p].done) begin
                    done_cnt[p]++;
                    done_cycle[p] = cycle;
                    assert (done_cnt[p] <= issued[p]) else begin
                        $display("%s: port %0d pulsed done with no read outstanding", cur_test, p);
                        errors++;
                    end
                    if (done_cnt[p] <= issued[p]) begin
                        assert (rsp[p].data == exp_data[p]) else begin
                            $display("mismatch %s port %0d data: expected %h, actual %h",
                                     cur_test, p, exp_data[p], rsp[p].data);
                            errors++;
                        end
                        assert (!rsp[p].err) else begin
                            $display("%s: port %0d got an error response", cur_test, p);
                            errors++;
                        end
                    end
                end
            end
        end
    end

    initial begin : watchdog
        while (cycle < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle++;
        end
        $display("timeout after %0d cycles, a read never completed", cycle);
        $display("=== FAIL ===");
        $finish;
    end

    initial begin : stimulus
        int errs;
        int mem_before;
        int mmio_before;
        int done_before;
        reset_i = 1'b1;
        req     = '0;
        issued  = '{default: 0};
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;

        cur_test = "reset_idle";
        errs     = errors;
        repeat (3) begin
            @(negedge clk);
            assert (!mem_ar.valid && !mmio_ar.valid && !mem_r_ready && !mmio_r_ready
                    && !rsp[0].done && !rsp[1].done) else begin
                $display("%s: a handshake output is active before any request", cur_test);
                errors++;
            end
        end
        report_test(errs);

        cur_test    = "fetch_mem";
        errs        = errors;
        mem_before  = mem_ar_count;
        mmio_before = mmio_ar_count;
        do_read(PORT_FETCH, 64'h0000_0000_8000_1000, SIZE_WORD);
        check_value("mem ar count", 1, mem_ar_count - mem_before);
        check_value("mmio ar count", 0, mmio_ar_count - mmio_before);
        check_value("mem ar size", SIZE_WORD, mem_last_size);
        check_value("mem ar prot", PROT_INSTR, mem_last_prot);
        report_test(errs);

        cur_test    = "load_mmio";
        errs        = errors;
        mem_before  = mem_ar_count;
        mmio_before = mmio_ar_count;
        do_read(PORT_LOAD, 64'h0000_0000_A000_0040, 3'd1);
        check_value("mem ar count", 0, mem_ar_count - mem_before);
        check_value("mmio ar count", 1, mmio_ar_count - mmio_before);
        check_value("mmio ar size", 1, mmio_last_size);
        check_value("mmio ar prot", PROT_DATA, mmio_last_prot);
        report_test(errs);

        cur_test = "same_cycle";    // load wins the tie
        errs     = errors;
        fork
            do_read(PORT_LOAD, 64'h0000_0000_0000_2008, 3'd3);
            do_read(PORT_FETCH, 64'h0000_0000_0000_3000, SIZE_WORD);
        join
        assert (done_cycle[PORT_LOAD] < done_cycle[PORT_FETCH]) else begin
            $display("%s: fetch finished before the load", cur_test);
            errors++;
        end
        report_test(errs);

        cur_test    = "random_mix";
        errs        = errors;
        done_before = done_cnt[0] + done_cnt[1];
        fork
            random_reads(PORT_FETCH, 20);
            random_reads(PORT_LOAD, 20);
        join
        check_value("done pulses", 40, done_cnt[0] + done_cnt[1] - done_before);
        report_test(errs);

        $display("tests %0d, passed %0d, failed %0d, errors %0d",
                 tests_run, tests_run - tests_failed, tests_failed, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== project.f ====
source/core_bus_pkg.sv
source/axi_lite_pkg.sv
source/axi_read_master.sv
source/axi_read_crossbar.sv
source/core_bus_top.sv
test/tb_core_bus_top.sv

// ==== Makefile ====
# Verilator build and run of the core bus testbench

VERILATOR ?= verilator
TOP       ?= tb_core_bus_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j $(JOBS)
PASS_TEXT ?= === PASS ===

SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean build

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG JOBS VFLAGS"

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) source/*.sv test/*.sv
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

test: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
